/* verilog/prefix_fe_pkg.sv */
// Prefix feature extraction package
// Holds the sizing constants of the feature stage and the feature
// configuration word, which is decoded either as a match or a range

package prefix_fe_pkg;

  // Counter and configuration geometry
  localparam int num_ctr      = 16;
  localparam int feat_per_ctr = 4;
  localparam int num_feat     = num_ctr * feat_per_ctr;

  // Stream geometry in bytes
  localparam int beat_bytes    = 8;
  localparam int quarter_bytes = 1024;
  localparam int block_bytes   = 4096;

  // Byte offset width, wide enough to hold block_bytes itself
  localparam int off_w = $clog2(block_bytes) + 1;
  localparam logic [off_w-1:0] block_off = off_w'(block_bytes);

  // Width of the per-beat hit count, which runs from 0 to beat_bytes
  localparam int hit_w = $clog2(beat_bytes) + 1;

  // Quarter counts saturate here
  localparam logic [7:0] cnt_max = 8'd255;

  // Values of the mode bit
  localparam logic mode_match = 1'b0;
  localparam logic mode_range = 1'b1;

  // Match view: a byte hits when (byte & mask) == (value & mask)
  typedef struct packed {
    logic       mode;
    logic       en;
    logic [7:0] value;
    logic [7:0] mask;
  } feat_match_t;

  // Range view: a byte hits when lo <= byte <= hi
  typedef struct packed {
    logic       mode;
    logic       en;
    logic [7:0] lo;
    logic [7:0] hi;
  } feat_range_t;

  // Both views share the mode and enable bits at the top
  typedef union packed {
    feat_match_t m;
    feat_range_t r;
  } feature_t;

endpackage

/* verilog/prefix_fe_cfg_regs.sv */
// Feature configuration register file
// Holds the 64 feature configurations used by the counter group and
// updates one entry per write strobe. All entries come out of reset disabled

module prefix_fe_cfg_regs (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    cfg_wr,
  input  logic [5:0]              cfg_addr,
  input  prefix_fe_pkg::feature_t cfg_data,
  input  logic                    block_open,
  output prefix_fe_pkg::feature_t fe_config [prefix_fe_pkg::num_feat]
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < prefix_fe_pkg::num_feat; i++) begin
        fe_config[i] <= '0;
      end
    end else if (cfg_wr) begin
      fe_config[cfg_addr] <= cfg_data;
    end
  end

  // A write while a block is open would change the rules halfway through
  // the block, since the controller and the counters work on the same block
  a_no_wr_in_block: assert property (
    @(posedge clk) disable iff (!arst_n)
    cfg_wr |-> !block_open
  ) else $error("Configuration write while a block is open");

endmodule

/* verilog/prefix_fe_ctrl.sv */
// Prefix feature block controller
// Registers each input beat, tracks the byte offset inside the open block
// and selects the 1 KB quarter the beat belongs to. Ends the block on eob
// or when the offset reaches 4096 bytes

module prefix_fe_ctrl (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [63:0] char_in,
  input  logic [7:0]  vbytes,
  input  logic        eob,
  output logic [63:0] beat_char,
  output logic [7:0]  beat_vbytes,
  output logic [1:0]  sel_q,
  output logic        blk_end,
  output logic        block_open
);

  logic [prefix_fe_pkg::off_w-1:0] offset_q;
  logic [prefix_fe_pkg::off_w-1:0] beat_len;
  logic [prefix_fe_pkg::off_w-1:0] next_off;
  logic                            has_data;
  logic                            end_beat;

  // Lanes are contiguous from lane 0, so the popcount is the beat length
  always_comb begin
    has_data = |vbytes;
    beat_len = '0;
    for (int k = 0; k < prefix_fe_pkg::beat_bytes; k++) begin
      beat_len = beat_len + {{(prefix_fe_pkg::off_w-1){1'b0}}, vbytes[k]};
    end
    next_off = offset_q + beat_len;
    end_beat = has_data && (eob || (next_off >= prefix_fe_pkg::block_off));
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      offset_q    <= '0;
      beat_vbytes <= '0;
      sel_q       <= '0;
      blk_end     <= 1'b0;
      block_open  <= 1'b0;
    end else begin
      beat_vbytes <= vbytes;
      blk_end     <= end_beat;
      // The quarter comes from the offset at the start of the beat
      sel_q       <= offset_q[$clog2(prefix_fe_pkg::quarter_bytes) +: 2];
      if (has_data) begin
        offset_q   <= end_beat ? '0 : next_off;
        block_open <= !end_beat;
      end
    end
  end

  // Registered beat payload, one cycle behind char_in
  always_ff @(posedge clk) begin
    beat_char <= char_in;
  end

  a_vbytes_contig: assert property (
    @(posedge clk) disable iff (!arst_n)
    (vbytes & (vbytes + 8'd1)) == 8'd0
  ) else $error("vbytes lanes are not contiguous from lane 0");

  a_eob_has_data: assert property (
    @(posedge clk) disable iff (!arst_n)
    eob |-> has_data
  ) else $error("eob on a beat without data");

  // Quarter boundaries must fall between beats, so only the last beat is short
  a_short_beat_eob: assert property (
    @(posedge clk) disable iff (!arst_n)
    (has_data && (vbytes != 8'hff)) |-> eob
  ) else $error("Partial beat without eob");

endmodule

/* verilog/prefix_fe_ctr.sv */
// Single prefix feature counter
// Checks every valid byte of a beat against four feature configurations
// and counts the bytes that hit any of them into four saturating 1 KB
// quarter counts. Publishes and clears the counts at the end of a block

module prefix_fe_ctr (
  input  logic                    clk,
  input  logic                    arst_n,
  input  prefix_fe_pkg::feature_t fe_config [prefix_fe_pkg::feat_per_ctr],
  input  logic [63:0]             beat_char,
  input  logic [7:0]              beat_vbytes,
  input  logic [1:0]              sel_q,
  input  logic                    blk_end,
  output logic [7:0]              cnt_1k,
  output logic [7:0]              cnt_2k,
  output logic [7:0]              cnt_3k,
  output logic [7:0]              cnt_4k,
  output logic                    result_valid
);

  logic [prefix_fe_pkg::beat_bytes-1:0] byte_hit;
  logic [prefix_fe_pkg::hit_w-1:0]      hit_cnt;
  logic [7:0]                           work [4];
  logic [7:0]                           upd  [4];

  function automatic logic [7:0] sat_add(input logic [7:0] a,
                                         input logic [prefix_fe_pkg::hit_w-1:0] b);
    logic [8:0] s;
    s = {1'b0, a} + {{(9-prefix_fe_pkg::hit_w){1'b0}}, b};
    return (s > {1'b0, prefix_fe_pkg::cnt_max}) ? prefix_fe_pkg::cnt_max : s[7:0];
  endfunction

  function automatic logic feat_hit(input prefix_fe_pkg::feature_t cfg,
                                    input logic [7:0] ch);
    logic hit;
    if (!cfg.m.en) begin
      hit = 1'b0;
    end else if (cfg.m.mode == prefix_fe_pkg::mode_range) begin
      hit = (ch >= cfg.r.lo) && (ch <= cfg.r.hi);
    end else begin
      hit = (ch & cfg.m.mask) == (cfg.m.value & cfg.m.mask);
    end
    return hit;
  endfunction

  // A byte counts once even when several configurations hit it
  always_comb begin
    hit_cnt = '0;
    for (int b = 0; b < prefix_fe_pkg::beat_bytes; b++) begin
      byte_hit[b] = 1'b0;
      for (int f = 0; f < prefix_fe_pkg::feat_per_ctr; f++) begin
        byte_hit[b] = byte_hit[b] | feat_hit(fe_config[f], beat_char[8*b +: 8]);
      end
      byte_hit[b] = byte_hit[b] & beat_vbytes[b];
      hit_cnt = hit_cnt + {{(prefix_fe_pkg::hit_w-1){1'b0}}, byte_hit[b]};
    end
  end

  always_comb begin
    for (int q = 0; q < 4; q++) begin
      upd[q] = (sel_q == 2'(q)) ? sat_add(work[q], hit_cnt) : work[q];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int q = 0; q < 4; q++) begin
        work[q] <= '0;
      end
      cnt_1k       <= '0;
      cnt_2k       <= '0;
      cnt_3k       <= '0;
      cnt_4k       <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= blk_end;
      if (blk_end) begin
        // The last beat is folded in on the way to the output registers
        cnt_1k <= upd[0];
        cnt_2k <= upd[1];
        cnt_3k <= upd[2];
        cnt_4k <= upd[3];
        for (int q = 0; q < 4; q++) begin
          work[q] <= '0;
        end
      end else begin
        for (int q = 0; q < 4; q++) begin
          work[q] <= upd[q];
        end
      end
    end
  end

endmodule

/* verilog/prefix_fe_grp.sv */
// Prefix feature counter group
// Sixteen feature counters that share one byte stream. Counter i uses
// configurations 4i to 4i+3 and drives byte i of each count bus

module prefix_fe_grp (
  input  logic                    clk,
  input  logic                    arst_n,
  input  prefix_fe_pkg::feature_t fe_config [prefix_fe_pkg::num_feat],
  input  logic [63:0]             beat_char,
  input  logic [7:0]              beat_vbytes,
  input  logic [1:0]              sel_q,
  input  logic                    blk_end,
  output logic [127:0]            ctr_1k,
  output logic [127:0]            ctr_2k,
  output logic [127:0]            ctr_3k,
  output logic [127:0]            ctr_4k,
  output logic                    result_valid
);

  logic [prefix_fe_pkg::num_ctr-1:0] rv_all;

  for (genvar i = 0; i < prefix_fe_pkg::num_ctr; i++) begin : g_ctr
    prefix_fe_pkg::feature_t ctr_cfg [prefix_fe_pkg::feat_per_ctr];

    for (genvar k = 0; k < prefix_fe_pkg::feat_per_ctr; k++) begin : g_cfg
      assign ctr_cfg[k] = fe_config[i*prefix_fe_pkg::feat_per_ctr + k];
    end

    prefix_fe_ctr u_ctr (
      .clk          (clk),
      .arst_n       (arst_n),
      .fe_config    (ctr_cfg),
      .beat_char    (beat_char),
      .beat_vbytes  (beat_vbytes),
      .sel_q        (sel_q),
      .blk_end      (blk_end),
      .cnt_1k       (ctr_1k[8*i +: 8]),
      .cnt_2k       (ctr_2k[8*i +: 8]),
      .cnt_3k       (ctr_3k[8*i +: 8]),
      .cnt_4k       (ctr_4k[8*i +: 8]),
      .result_valid (rv_all[i])
    );
  end

  // All counters see the same blk_end, so one of them speaks for the group
  assign result_valid = rv_all[0];

  a_rv_agree: assert property (
    @(posedge clk) disable iff (!arst_n)
    (rv_all == '0) || (rv_all == '1)
  ) else $error("Feature counters disagree on result_valid");

endmodule

/* verilog/prefix_fe_top.sv */
// Prefix feature extraction top level
// Connects the configuration registers, the block controller and the
// counter group. Counts of a block appear two cycles after its last beat

module prefix_fe_top (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic [63:0]             char_in,
  input  logic [7:0]              vbytes,
  input  logic                    eob,
  input  logic                    cfg_wr,
  input  logic [5:0]              cfg_addr,
  input  prefix_fe_pkg::feature_t cfg_data,
  output logic [127:0]            ctr_1k,
  output logic [127:0]            ctr_2k,
  output logic [127:0]            ctr_3k,
  output logic [127:0]            ctr_4k,
  output logic                    result_valid
);

  prefix_fe_pkg::feature_t fe_config [prefix_fe_pkg::num_feat];
  logic [63:0]             beat_char;
  logic [7:0]              beat_vbytes;
  logic [1:0]              sel_q;
  logic                    blk_end;
  logic                    block_open;

  prefix_fe_cfg_regs u_cfg_regs (
    .clk        (clk),
    .arst_n     (arst_n),
    .cfg_wr     (cfg_wr),
    .cfg_addr   (cfg_addr),
    .cfg_data   (cfg_data),
    .block_open (block_open),
    .fe_config  (fe_config)
  );

  prefix_fe_ctrl u_ctrl (
    .clk         (clk),
    .arst_n      (arst_n),
    .char_in     (char_in),
    .vbytes      (vbytes),
    .eob         (eob),
    .beat_char   (beat_char),
    .beat_vbytes (beat_vbytes),
    .sel_q       (sel_q),
    .blk_end     (blk_end),
    .block_open  (block_open)
  );

  prefix_fe_grp u_grp (
    .clk          (clk),
    .arst_n       (arst_n),
    .fe_config    (fe_config),
    .beat_char    (beat_char),
    .beat_vbytes  (beat_vbytes),
    .sel_q        (sel_q),
    .blk_end      (blk_end),
    .ctr_1k       (ctr_1k),
    .ctr_2k       (ctr_2k),
    .ctr_3k       (ctr_3k),
    .ctr_4k       (ctr_4k),
    .result_valid (result_valid)
  );

endmodule

/* verification/prefix_fe_ref.svh */
// Reference model of the prefix feature counters
// Computes the expected count buses of one block, packed as
// {ctr_4k, ctr_3k, ctr_2k, ctr_1k}, from the configurations and the bytes

`ifndef PREFIX_FE_REF_SVH
`define PREFIX_FE_REF_SVH

function automatic logic [511:0] prefix_fe_expect(
  input prefix_fe_pkg::feature_t cfg [prefix_fe_pkg::num_feat],
  input logic [7:0]              data [prefix_fe_pkg::block_bytes],
  input int                      len
);
  int                      cnt [prefix_fe_pkg::num_ctr][4];
  logic [511:0]            res;
  prefix_fe_pkg::feature_t f;
  int                      q;
  logic                    hit;
  res = '0;
  for (int i = 0; i < prefix_fe_pkg::num_ctr; i++) begin
    for (int j = 0; j < 4; j++) begin
      cnt[i][j] = 0;
    end
  end
  for (int n = 0; n < len; n++) begin
    // The beat that carries byte n decides the quarter
    q = ((n / prefix_fe_pkg::beat_bytes) * prefix_fe_pkg::beat_bytes) /
        prefix_fe_pkg::quarter_bytes;
    for (int i = 0; i < prefix_fe_pkg::num_ctr; i++) begin
      hit = 1'b0;
      for (int k = 0; k < prefix_fe_pkg::feat_per_ctr; k++) begin
        f = cfg[i*prefix_fe_pkg::feat_per_ctr + k];
        if (f.r.en && f.r.mode) begin
          hit = hit | ((data[n] >= f.r.lo) && (data[n] <= f.r.hi));
        end else if (f.m.en) begin
          hit = hit | (((data[n] ^ f.m.value) & f.m.mask) == 8'h00);
        end
      end
      if (hit) begin
        cnt[i][q]++;
      end
    end
  end
  // Clamping the total once is the same as saturating every addition
  for (int i = 0; i < prefix_fe_pkg::num_ctr; i++) begin
    for (int j = 0; j < 4; j++) begin
      res[128*j + 8*i +: 8] = (cnt[i][j] > int'(prefix_fe_pkg::cnt_max)) ?
                              prefix_fe_pkg::cnt_max : 8'(cnt[i][j]);
    end
  end
  return res;
endfunction

`endif

/* verification/prefix_fe_tb.sv */
// Testbench for the prefix feature extraction stage
// Writes feature configurations, streams byte blocks into the top level,
// predicts the count buses with a reference model and checks each result

module prefix_fe_tb;

  // Five blocks of up to 513 beats, four sets of 64 writes, plus margin
  localparam int max_cycles = 6000;

  logic                    clk;
  logic                    arst_n;
  logic [63:0]             char_in;
  logic [7:0]              vbytes;
  logic                    eob;
  logic                    cfg_wr;
  logic [5:0]              cfg_addr;
  prefix_fe_pkg::feature_t cfg_data;
  logic [127:0]            ctr_1k;
  logic [127:0]            ctr_2k;
  logic [127:0]            ctr_3k;
  logic [127:0]            ctr_4k;
  logic                    result_valid;

  prefix_fe_pkg::feature_t cfg_model [prefix_fe_pkg::num_feat];
  logic [7:0]              blk_data [prefix_fe_pkg::block_bytes];
  logic [511:0]            exp_q [$];
  int                      edge_q [$];
  int                      cycles;
  int                      errors;
  int                      test_err0;
  int                      tests_pass;
  int                      tests_fail;

  `include "prefix_fe_ref.svh"

  prefix_fe_top uut (
    .clk          (clk),
    .arst_n       (arst_n),
    .char_in      (char_in),
    .vbytes       (vbytes),
    .eob          (eob),
    .cfg_wr       (cfg_wr),
    .cfg_addr     (cfg_addr),
    .cfg_data     (cfg_data),
    .ctr_1k       (ctr_1k),
    .ctr_2k       (ctr_2k),
    .ctr_3k       (ctr_3k),
    .ctr_4k       (ctr_4k),
    .result_valid (result_valid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_bus(input string name, input logic [127:0] got,
                           input logic [127:0] want);
    assert (got == want) else begin
      $display("ERR %0t: %s is %h, expected %h", $time, name, got, want);
      errors++;
    end
  endtask

  // Outputs are sampled at the rising edge, before the DUT updates them
  always @(posedge clk) begin
    logic [511:0] exp_bus;
    int           edge_n;
    if (arst_n && result_valid) begin
      if (exp_q.size() == 0) begin
        $display("result_valid pulsed at time %0t with no block pending", $time);
        errors++;
      end else begin
        exp_bus = exp_q.pop_front();
        edge_n  = edge_q.pop_front();
        assert (cycles == edge_n + 2) else begin
          $display("ERR %0t: result_valid came %0d cycles after the last beat, expected 2",
                   $time, cycles - edge_n);
          errors++;
        end
        check_bus("ctr_1k", ctr_1k, exp_bus[127:0]);
        check_bus("ctr_2k", ctr_2k, exp_bus[255:128]);
        check_bus("ctr_3k", ctr_3k, exp_bus[383:256]);
        check_bus("ctr_4k", ctr_4k, exp_bus[511:384]);
      end
    end
    cycles++;
    if (cycles >= max_cycles) begin
      $display("Timeout: the run reached %0d cycles without finishing", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic prefix_fe_pkg::feature_t make_match(input logic en,
      input logic [7:0] value, input logic [7:0] mask);
    prefix_fe_pkg::feature_t f;
    f.m.mode  = prefix_fe_pkg::mode_match;
    f.m.en    = en;
    f.m.value = value;
    f.m.mask  = mask;
    return f;
  endfunction

  function automatic prefix_fe_pkg::feature_t make_range(input logic en,
      input logic [7:0] lo, input logic [7:0] hi);
    prefix_fe_pkg::feature_t f;
    f.r.mode = prefix_fe_pkg::mode_range;
    f.r.en   = en;
    f.r.lo   = lo;
    f.r.hi   = hi;
    return f;
  endfunction

  task automatic write_cfg(input int addr, input prefix_fe_pkg::feature_t f);
    @(negedge clk);
    cfg_wr          = 1'b1;
    cfg_addr        = 6'(addr);
    cfg_data        = f;
    cfg_model[addr] = f;
  endtask

  // Style 0 is random match, 1 mixes match and range with some disabled,
  // 2 enables one exact match on 8'h5a per counter
  task automatic load_cfgs(input int style);
    prefix_fe_pkg::feature_t f;
    logic [7:0]              lo;
    for (int a = 0; a < prefix_fe_pkg::num_feat; a++) begin
      lo = 8'($urandom);
      if (style == 0) begin
        f = make_match(1'b1, 8'($urandom), 8'($urandom) | 8'h0f);
      end else if (style == 1 && ($urandom % 2 == 0)) begin
        f = make_range($urandom % 4 != 0, lo,
                       (lo > 8'd239) ? 8'hff : lo + 8'($urandom % 16));
      end else if (style == 1) begin
        f = make_match($urandom % 4 != 0, lo, 8'($urandom) | 8'h0f);
      end else begin
        f = make_match(a % prefix_fe_pkg::feat_per_ctr == 0, 8'h5a, 8'hff);
      end
      write_cfg(a, f);
    end
    @(negedge clk);
    cfg_wr = 1'b0;
  endtask

  task automatic fill_block(input bit random_bytes, input logic [7:0] value);
    for (int n = 0; n < prefix_fe_pkg::block_bytes; n++) begin
      blk_data[n] = random_bytes ? 8'($urandom) : value;
    end
  endtask

  // Optionally rewrites one configuration together with the first beat
  task automatic send_block(input int len, input bit use_eob, input bit wr_first,
                            input int wr_addr, input prefix_fe_pkg::feature_t wr_cfg);
    int nb;
    for (int off = 0; off < len; off += prefix_fe_pkg::beat_bytes) begin
      @(negedge clk);
      nb = (len - off < 8) ? len - off : 8;
      for (int k = 0; k < 8; k++) begin
        // Lanes past the end carry junk that must not count
        char_in[8*k +: 8] = (k < nb) ? blk_data[off + k] : 8'($urandom);
      end
      vbytes = 8'((9'd1 << nb) - 9'd1);
      eob    = use_eob && (off + 8 >= len);
      cfg_wr = wr_first && (off == 0);
      if (wr_first && off == 0) begin
        cfg_addr           = 6'(wr_addr);
        cfg_data           = wr_cfg;
        cfg_model[wr_addr] = wr_cfg;
      end
    end
    exp_q.push_back(prefix_fe_expect(cfg_model, blk_data, len));
    // The next rising edge samples the last beat and sees this cycle count
    edge_q.push_back(cycles);
  endtask

  task automatic go_idle();
    @(negedge clk);
    char_in = '0;
    vbytes  = '0;
    eob     = 1'b0;
    cfg_wr  = 1'b0;
  endtask

  task automatic wait_results();
    int deadline;
    if (edge_q.size() == 0) return;
    deadline = edge_q[$] + 8;
    while (edge_q.size() > 0) begin
      @(negedge clk);
      if (cycles > deadline) begin
        $display("No result_valid pulse arrived for %0d pending block(s)", edge_q.size());
        errors += edge_q.size();
        exp_q.delete();
        edge_q.delete();
      end
    end
  endtask

  task automatic finish_test(input string name);
    if (errors == test_err0) begin
      tests_pass++;
      $display("Test %s: ok", name);
    end else begin
      tests_fail++;
      $display("Test %s: FAILED with %0d errors", name, errors - test_err0);
    end
    test_err0 = errors;
  endtask

  initial begin
    int len_a;
    int len_b;
    void'($urandom(32'h90e3c9d1));
    arst_n     = 1'b0;
    char_in    = '0;
    vbytes     = '0;
    eob        = 1'b0;
    cfg_wr     = 1'b0;
    cfg_addr   = '0;
    cfg_data   = '0;
    cycles     = 0;
    errors     = 0;
    test_err0  = 0;
    tests_pass = 0;
    tests_fail = 0;
    for (int a = 0; a < prefix_fe_pkg::num_feat; a++) begin
      cfg_model[a] = '0;
    end
    repeat (2) @(negedge clk);
    arst_n = 1'b1;

    repeat (3) begin
      @(negedge clk);
      assert (!result_valid && ctr_1k == '0 && ctr_2k == '0 && ctr_3k == '0 &&
              ctr_4k == '0) else begin
        $display("ERR %0t: outputs are not idle after reset", $time);
        errors++;
      end
    end
    finish_test("1 reset state");

    load_cfgs(0);
    fill_block(1'b1, 8'h00);
    send_block(prefix_fe_pkg::block_bytes, 1'b0, 1'b0, 0, '0);
    go_idle();
    wait_results();
    finish_test("2 full random block");

    // Last beat is partial and starts inside quarter 2
    load_cfgs(1);
    fill_block(1'b1, 8'h00);
    len_a = 2048 + 8 * int'($urandom % 128) + 1 + int'($urandom % 7);
    send_block(len_a, 1'b1, 1'b0, 0, '0);
    go_idle();
    wait_results();
    check_bus("ctr_4k after early eob", ctr_4k, '0);
    finish_test("3 mixed modes with eob");

    load_cfgs(2);
    fill_block(1'b0, 8'h5a);
    send_block(prefix_fe_pkg::block_bytes, 1'b0, 1'b0, 0, '0);
    go_idle();
    wait_results();
    check_bus("saturated ctr_1k", ctr_1k, {16{8'hff}});
    check_bus("saturated ctr_4k", ctr_4k, {16{8'hff}});
    finish_test("4 saturation");

    // Entry 0 becomes a match-all while the second block starts
    load_cfgs(1);
    fill_block(1'b1, 8'h00);
    len_a = 8 * (20 + int'($urandom % 40)) + 1 + int'($urandom % 8);
    send_block(len_a, 1'b1, 1'b0, 0, '0);
    fill_block(1'b1, 8'h00);
    len_b = 8 * (40 + int'($urandom % 40)) + 1 + int'($urandom % 8);
    send_block(len_b, 1'b1, 1'b1, 0, make_match(1'b1, 8'h00, 8'h00));
    go_idle();
    wait_results();
    finish_test("5 back to back blocks");

    $display("Tests passed: %0d, tests failed: %0d", tests_pass, tests_fail);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+verification
verilog/prefix_fe_pkg.sv
verilog/prefix_fe_cfg_regs.sv
verilog/prefix_fe_ctrl.sv
verilog/prefix_fe_ctr.sv
verilog/prefix_fe_grp.sv
verilog/prefix_fe_top.sv
verification/prefix_fe_tb.sv

/* run.sh */
#!/bin/sh
# Builds the prefix feature testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module prefix_fe_tb -o prefix_fe_sim

status=0
./obj_dir/prefix_fe_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "^Testbench passed$" sim.log; then
  exit 0
fi
echo "Simulation did not pass (exit status $status)"
exit 1
